// File: md_pkg.sv
// Shared types for the multiply/divide unit
// Operand and result width is fixed at 32 bits; sign mode bit 0 is
// operand a and bit 1 is operand b

package md_pkg;

  // Word width as a 6-bit constant
  localparam logic [5:0] WORD_W = 6'd32;

  // Half-operand width of the multiply step
  localparam int HALF_W = 16;

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [1:0] {
    MD_MUL  = 2'd0,
    MD_MULH = 2'd1,
    MD_DIV  = 2'd2,
    MD_REM  = 2'd3
  } md_op_e;

  // Bit 0 marks a as signed, bit 1 marks b as signed
  typedef logic [1:0] md_sign_t;

  // Multiplier steps, ALBL doubles as the idle state
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

// File: md_mult.sv
// Multi-cycle multiplier, one 17x17 signed MAC over 16-bit operand halves
// MUL is done after 3 steps and MULH after 4; the first step runs in the
// accept cycle straight from the request lines
// Result and valid are held until res_ready_i

`timescale 1ns/1ps

module md_mult #(
  parameter int TAG_W = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  md_pkg::md_op_e    req_op_i,
  input  md_pkg::md_sign_t  req_sign_i,
  input  md_pkg::word_t     req_a_i,
  input  md_pkg::word_t     req_b_i,
  input  logic [TAG_W-1:0]  req_tag_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output md_pkg::word_t     res_data_o,
  output logic [TAG_W-1:0]  res_tag_o
);

  localparam int H = md_pkg::HALF_W;

  md_pkg::mult_state_e state_q, state_d;
  md_pkg::word_t       a_q, b_q;
  md_pkg::md_op_e      op_q;
  md_pkg::md_sign_t    sign_q;
  logic [TAG_W-1:0]    tag_q;

  logic [33:0]         acc_q, acc_d, accum;
  logic [H-1:0]        mul_a, mul_b;
  logic                sign_a, sign_b;
  logic                signed_mult;
  logic                is_mul;
  logic                step;
  logic signed [33:0]  mac_res;

  assign is_mul      = (op_q == md_pkg::MD_MUL);
  assign signed_mult = (sign_q != 2'b00);

  // Top two bits of the true sum are always equal, so 34 bits suffice
  assign mac_res = $signed({sign_a, mul_a}) * $signed({sign_b, mul_b}) + $signed(accum);

  always_comb begin
    mul_a       = a_q[H-1:0];
    mul_b       = b_q[H-1:0];
    sign_a      = 1'b0;
    sign_b      = 1'b0;
    accum       = '0;
    acc_d       = mac_res;
    state_d     = state_q;
    res_valid_o = 1'b0;
    res_data_o  = mac_res[31:0];
    case (state_q)
      md_pkg::ALBL: begin
        // al*bl, taken from the request lines
        mul_a   = req_a_i[H-1:0];
        mul_b   = req_b_i[H-1:0];
        state_d = md_pkg::ALBH;
      end
      md_pkg::ALBH: begin
        mul_b  = b_q[2*H-1:H];
        sign_b = sign_q[1] & b_q[31];
        // al*bl is unsigned without carry
        accum  = {18'b0, acc_q[31:16]};
        if (is_mul) begin
          acc_d = {2'b0, mac_res[15:0], acc_q[15:0]};
        end
        state_d = md_pkg::AHBL;
      end
      md_pkg::AHBL: begin
        mul_a  = a_q[2*H-1:H];
        sign_a = sign_q[0] & a_q[31];
        if (is_mul) begin
          accum       = {18'b0, acc_q[31:16]};
          res_data_o  = {mac_res[15:0], acc_q[15:0]};
          res_valid_o = 1'b1;
          state_d     = md_pkg::ALBL;
        end else begin
          accum   = acc_q;
          state_d = md_pkg::AHBH;
        end
      end
      default: begin
        // ah*bh on the upper part of the running sum
        mul_a       = a_q[2*H-1:H];
        mul_b       = b_q[2*H-1:H];
        sign_a      = sign_q[0] & a_q[31];
        sign_b      = sign_q[1] & b_q[31];
        accum       = {{16{signed_mult & acc_q[33]}}, acc_q[33:16]};
        res_valid_o = 1'b1;
        state_d     = md_pkg::ALBL;
      end
    endcase
  end

  assign req_ready_o = (state_q == md_pkg::ALBL);
  assign res_tag_o   = tag_q;

  // Idle waits for a request, a finished result waits for res_ready_i
  assign step = (state_q == md_pkg::ALBL) ? req_valid_i : (~res_valid_o | res_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::ALBL;
    end else if (step) begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_valid_i) begin
      a_q    <= req_a_i;
      b_q    <= req_b_i;
      op_q   <= req_op_i;
      sign_q <= req_sign_i;
      tag_q  <= req_tag_i;
    end
    if (step) begin
      acc_q <= acc_d;
    end
  end

endmodule

// File: md_div.sv
// Restoring long divider for DIV and REM with its own 33-bit subtractor
// Divide by zero finishes after 2 cycles, any other divide after 37
// Most negative / -1 returns the most negative number and remainder 0
// Result and valid are held in DIV_FINISH until res_ready_i

`timescale 1ns/1ps

module md_div #(
  parameter int TAG_W = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  md_pkg::md_op_e    req_op_i,
  input  md_pkg::md_sign_t  req_sign_i,
  input  md_pkg::word_t     req_a_i,
  input  md_pkg::word_t     req_b_i,
  input  logic [TAG_W-1:0]  req_tag_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output md_pkg::word_t     res_data_o,
  output logic [TAG_W-1:0]  res_tag_o
);

  md_pkg::div_state_e state_q, state_d;
  logic [4:0]         cnt_q, cnt_dec;

  md_pkg::word_t      a_q, b_q;
  md_pkg::md_op_e     op_q;
  md_pkg::md_sign_t   sign_q;
  logic [TAG_W-1:0]   tag_q;
  md_pkg::word_t      num_q, den_q, rem_q, quo_q, res_q;

  logic [32:0]        sub_a, sub_b, sub_res;
  logic               is_ge;
  logic               neg_a, neg_b, neg_res;
  md_pkg::word_t      one_hot, next_rem, next_quo;

  assign neg_a   = sign_q[0] & a_q[31];
  assign neg_b   = sign_q[1] & b_q[31];
  assign neg_res = (op_q == md_pkg::MD_DIV) ? (neg_a ^ neg_b) : neg_a;

  // Subtractor: remainder minus divisor while dividing, else 0 - x
  assign sub_a = (state_q == md_pkg::DIV_COMP || state_q == md_pkg::DIV_LAST) ?
                 {1'b0, rem_q} : 33'd0;

  always_comb begin
    case (state_q)
      md_pkg::DIV_ABS_A: sub_b = {1'b0, a_q};
      md_pkg::DIV_ABS_B: sub_b = {1'b0, b_q};
      md_pkg::DIV_SIGN:  sub_b = {1'b0, res_q};
      default:           sub_b = {1'b0, den_q};
    endcase
  end

  assign sub_res  = sub_a - sub_b;
  assign is_ge    = ~sub_res[32];

  assign cnt_dec  = cnt_q - 5'd1;
  assign one_hot  = md_pkg::word_t'(1) << cnt_q;
  assign next_rem = is_ge ? sub_res[31:0] : rem_q;
  assign next_quo = is_ge ? (quo_q | one_hot) : quo_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      md_pkg::DIV_IDLE: begin
        if (req_valid_i) begin
          state_d = (req_b_i == '0) ? md_pkg::DIV_FINISH : md_pkg::DIV_ABS_A;
        end
      end
      md_pkg::DIV_ABS_A: state_d = md_pkg::DIV_ABS_B;
      md_pkg::DIV_ABS_B: state_d = md_pkg::DIV_COMP;
      md_pkg::DIV_COMP: begin
        if (cnt_q == 5'd1) begin
          state_d = md_pkg::DIV_LAST;
        end
      end
      md_pkg::DIV_LAST:  state_d = md_pkg::DIV_SIGN;
      md_pkg::DIV_SIGN:  state_d = md_pkg::DIV_FINISH;
      md_pkg::DIV_FINISH: begin
        if (res_ready_i) begin
          state_d = md_pkg::DIV_IDLE;
        end
      end
      default: state_d = md_pkg::DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == md_pkg::DIV_ABS_B) begin
        cnt_q <= 5'd31;
      end else if (state_q == md_pkg::DIV_COMP) begin
        cnt_q <= cnt_dec;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      md_pkg::DIV_IDLE: begin
        if (req_valid_i) begin
          a_q    <= req_a_i;
          b_q    <= req_b_i;
          op_q   <= req_op_i;
          sign_q <= req_sign_i;
          tag_q  <= req_tag_i;
          // Zero-divisor result, overwritten by a normal divide
          res_q  <= (req_op_i == md_pkg::MD_REM) ? req_a_i : '1;
        end
      end
      md_pkg::DIV_ABS_A: begin
        num_q <= neg_a ? sub_res[31:0] : a_q;
        quo_q <= '0;
      end
      md_pkg::DIV_ABS_B: begin
        den_q <= neg_b ? sub_res[31:0] : b_q;
        rem_q <= {31'b0, num_q[31]};
      end
      md_pkg::DIV_COMP: begin
        rem_q <= {next_rem[30:0], num_q[cnt_dec]};
        quo_q <= next_quo;
      end
      md_pkg::DIV_LAST: begin
        res_q <= (op_q == md_pkg::MD_DIV) ? next_quo : next_rem;
      end
      md_pkg::DIV_SIGN: begin
        if (neg_res) begin
          res_q <= sub_res[31:0];
        end
      end
      default: begin
      end
    endcase
  end

  assign req_ready_o = (state_q == md_pkg::DIV_IDLE);
  assign res_valid_o = (state_q == md_pkg::DIV_FINISH);
  assign res_data_o  = res_q;
  assign res_tag_o   = tag_q;

endmodule

// File: md_port_arb.sv
// Request steering and result arbitration for the two units
// MUL/MULH go to the multiplier, DIV/REM to the divider
// Result grant is round-robin with no register stage on the data path

`timescale 1ns/1ps

module md_port_arb #(
  parameter int TAG_W = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  md_pkg::md_op_e    req_op_i,
  input  md_pkg::md_sign_t  req_sign_i,
  input  md_pkg::word_t     req_a_i,
  input  md_pkg::word_t     req_b_i,
  input  logic [TAG_W-1:0]  req_tag_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output md_pkg::word_t     res_data_o,
  output logic [TAG_W-1:0]  res_tag_o,
  output logic              mul_req_valid_o,
  input  logic              mul_req_ready_i,
  output logic              div_req_valid_o,
  input  logic              div_req_ready_i,
  output md_pkg::md_op_e    req_op_o,
  output md_pkg::md_sign_t  req_sign_o,
  output md_pkg::word_t     req_a_o,
  output md_pkg::word_t     req_b_o,
  output logic [TAG_W-1:0]  req_tag_o,
  input  logic              mul_res_valid_i,
  input  md_pkg::word_t     mul_res_data_i,
  input  logic [TAG_W-1:0]  mul_res_tag_i,
  output logic              mul_res_ready_o,
  input  logic              div_res_valid_i,
  input  md_pkg::word_t     div_res_data_i,
  input  logic [TAG_W-1:0]  div_res_tag_i,
  output logic              div_res_ready_o
);

  logic sel_mul;
  logic grant_div;
  // Divider wins a tie when set
  logic prio_div_q;

  assign sel_mul = (req_op_i == md_pkg::MD_MUL) || (req_op_i == md_pkg::MD_MULH);

  assign mul_req_valid_o = req_valid_i & sel_mul;
  assign div_req_valid_o = req_valid_i & ~sel_mul;
  assign req_ready_o     = sel_mul ? mul_req_ready_i : div_req_ready_i;

  assign req_op_o   = req_op_i;
  assign req_sign_o = req_sign_i;
  assign req_a_o    = req_a_i;
  assign req_b_o    = req_b_i;
  assign req_tag_o  = req_tag_i;

  assign grant_div = div_res_valid_i & (~mul_res_valid_i | prio_div_q);

  assign res_valid_o     = mul_res_valid_i | div_res_valid_i;
  assign res_data_o      = grant_div ? div_res_data_i : mul_res_data_i;
  assign res_tag_o       = grant_div ? div_res_tag_i : mul_res_tag_i;
  assign mul_res_ready_o = res_ready_i & ~grant_div;
  assign div_res_ready_o = res_ready_i & grant_div;

  // A stalled grant keeps its priority so the output stays stable,
  // after a transfer the other unit is preferred
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_div_q <= 1'b0;
    end else if (res_valid_o) begin
      prio_div_q <= res_ready_i ? ~grant_div : grant_div;
    end
  end

endmodule

// File: md_top.sv
// Multiply/divide unit with tagged requests and out-of-order results
// A multiply and a divide can be in flight at the same time

`timescale 1ns/1ps

module md_top #(
  parameter int TAG_W = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  md_pkg::md_op_e    req_op_i,
  input  md_pkg::md_sign_t  req_sign_i,
  input  md_pkg::word_t     req_a_i,
  input  md_pkg::word_t     req_b_i,
  input  logic [TAG_W-1:0]  req_tag_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output md_pkg::word_t     res_data_o,
  output logic [TAG_W-1:0]  res_tag_o
);

  logic             mul_req_valid, mul_req_ready, div_req_valid, div_req_ready;
  md_pkg::md_op_e   op;
  md_pkg::md_sign_t sign;
  md_pkg::word_t    a, b;
  logic [TAG_W-1:0] tag;
  logic             mul_res_valid, mul_res_ready, div_res_valid, div_res_ready;
  md_pkg::word_t    mul_res_data, div_res_data;
  logic [TAG_W-1:0] mul_res_tag, div_res_tag;

  md_port_arb #(.TAG_W(TAG_W)) u_arb (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_op_i, .req_sign_i, .req_a_i, .req_b_i, .req_tag_i,
    .res_valid_o, .res_ready_i, .res_data_o, .res_tag_o,
    .mul_req_valid_o(mul_req_valid), .mul_req_ready_i(mul_req_ready),
    .div_req_valid_o(div_req_valid), .div_req_ready_i(div_req_ready),
    .req_op_o(op), .req_sign_o(sign), .req_a_o(a), .req_b_o(b), .req_tag_o(tag),
    .mul_res_valid_i(mul_res_valid), .mul_res_data_i(mul_res_data),
    .mul_res_tag_i(mul_res_tag), .mul_res_ready_o(mul_res_ready),
    .div_res_valid_i(div_res_valid), .div_res_data_i(div_res_data),
    .div_res_tag_i(div_res_tag), .div_res_ready_o(div_res_ready)
  );

  md_mult #(.TAG_W(TAG_W)) u_mult (
    .clk_i, .rst_ni,
    .req_valid_i(mul_req_valid), .req_ready_o(mul_req_ready),
    .req_op_i(op), .req_sign_i(sign), .req_a_i(a), .req_b_i(b), .req_tag_i(tag),
    .res_valid_o(mul_res_valid), .res_ready_i(mul_res_ready),
    .res_data_o(mul_res_data), .res_tag_o(mul_res_tag)
  );

  md_div #(.TAG_W(TAG_W)) u_div (
    .clk_i, .rst_ni,
    .req_valid_i(div_req_valid), .req_ready_o(div_req_ready),
    .req_op_i(op), .req_sign_i(sign), .req_a_i(a), .req_b_i(b), .req_tag_i(tag),
    .res_valid_o(div_res_valid), .res_ready_i(div_res_ready),
    .res_data_o(div_res_data), .res_tag_o(div_res_tag)
  );

endmodule

// File: md_sva.sv
// Handshake checks on the md_top ports, bound into every md_top
// Data and tag are only required to be known while res_valid_o is high

`timescale 1ns/1ps

module md_sva #(
  parameter int TAG_W = 4
) (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             req_ready_o,
  input logic             res_valid_o,
  input logic             res_ready_i,
  input md_pkg::word_t    res_data_o,
  input logic [TAG_W-1:0] res_tag_o
);

  // A stalled result keeps its valid, data and tag
  a_res_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=>
      res_valid_o && $stable(res_data_o) && $stable(res_tag_o))
    else $error("Stalled result was dropped or changed");

  a_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({req_ready_o, res_valid_o}) &&
      (!res_valid_o || !$isunknown({res_data_o, res_tag_o})))
    else $error("Unknown value on an output");

  a_ready_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> req_ready_o)
    else $error("req_ready_o low in the first cycle after reset");

endmodule

bind md_top md_sva #(.TAG_W(TAG_W)) u_sva (.*);

// File: tb_md.sv
// Testbench for md_top with a fixed corner table followed by LCG entries
// Requests go out in order, one at a time; results may return out of order
// Tag is the entry index mod 16, so at most 16 entries are outstanding

`timescale 1ns/1ps

module tb_md;

  localparam int TAG_W    = 4;
  localparam int NUM_TAGS = 2 ** TAG_W;
  localparam int NUM_RAND = 40;

  logic             clk_i;
  logic             rst_ni;
  logic             req_valid_i;
  logic             req_ready_o;
  md_pkg::md_op_e   req_op_i;
  md_pkg::md_sign_t req_sign_i;
  md_pkg::word_t    req_a_i;
  md_pkg::word_t    req_b_i;
  logic [TAG_W-1:0] req_tag_i;
  logic             res_valid_o;
  logic             res_ready_i;
  md_pkg::word_t    res_data_o;
  logic [TAG_W-1:0] res_tag_o;

  md_top #(.TAG_W(TAG_W)) u_md_top (.*);

  // Stimulus table with expected results
  md_pkg::md_op_e   ent_op[$];
  md_pkg::md_sign_t ent_sign[$];
  md_pkg::word_t    ent_a[$];
  md_pkg::word_t    ent_b[$];
  md_pkg::word_t    ent_exp[$];

  // Scoreboard indexed by tag
  bit               busy[NUM_TAGS];
  md_pkg::word_t    exp_of_tag[NUM_TAGS];
  int               idx_of_tag[NUM_TAGS];

  logic [31:0]      lcg_state = 32'd54440;
  int               err_value = 0;
  int               err_tag = 0;
  int               err_other = 0;
  int               n_entries = 0;
  int               done_cnt = 0;
  int               cycles = 0;
  int               cycle_limit = 0;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference result from 64-bit arithmetic on the extended operands
  function automatic md_pkg::word_t model_result(input md_pkg::md_op_e op,
      input md_pkg::md_sign_t sm, input md_pkg::word_t a, input md_pkg::word_t b);
    logic signed [63:0] va, vb, prod, quo, rem;
    va   = sm[0] ? {{32{a[31]}}, a} : {32'd0, a};
    vb   = sm[1] ? {{32{b[31]}}, b} : {32'd0, b};
    prod = va * vb;
    if (op == md_pkg::MD_MUL) return prod[31:0];
    if (op == md_pkg::MD_MULH) return prod[63:32];
    if (b == '0) return (op == md_pkg::MD_DIV) ? '1 : a;
    quo = va / vb;
    rem = va % vb;
    return (op == md_pkg::MD_DIV) ? quo[31:0] : rem[31:0];
  endfunction

  task automatic add_entry(input md_pkg::md_op_e op, input md_pkg::md_sign_t sm,
      input md_pkg::word_t a, input md_pkg::word_t b, input md_pkg::word_t exp);
    ent_op.push_back(op);
    ent_sign.push_back(sm);
    ent_a.push_back(a);
    ent_b.push_back(b);
    ent_exp.push_back(exp);
  endtask

  task automatic load_table();
    add_entry(md_pkg::MD_MUL,  2'b00, 32'h0000_0003, 32'h0000_0007, 32'h0000_0015);
    add_entry(md_pkg::MD_MUL,  2'b00, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
    add_entry(md_pkg::MD_MUL,  2'b11, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
    add_entry(md_pkg::MD_MUL,  2'b01, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_entry(md_pkg::MD_MUL,  2'b10, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_entry(md_pkg::MD_MUL,  2'b00, 32'h0000_0000, 32'hDEAD_BEEF, 32'h0000_0000);
    add_entry(md_pkg::MD_MULH, 2'b00, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    add_entry(md_pkg::MD_MULH, 2'b11, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
    add_entry(md_pkg::MD_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_entry(md_pkg::MD_MULH, 2'b11, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF);
    add_entry(md_pkg::MD_MULH, 2'b01, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_entry(md_pkg::MD_MULH, 2'b10, 32'h0000_0002, 32'h8000_0000, 32'hFFFF_FFFF);
    add_entry(md_pkg::MD_MULH, 2'b11, 32'h1234_5678, 32'h0001_0000, 32'h0000_1234);
    add_entry(md_pkg::MD_DIV,  2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_entry(md_pkg::MD_REM,  2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_entry(md_pkg::MD_DIV,  2'b11, 32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD);
    add_entry(md_pkg::MD_REM,  2'b11, 32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF);
    add_entry(md_pkg::MD_DIV,  2'b00, 32'hFFFF_FFF9, 32'h0000_0002, 32'h7FFF_FFFC);
    add_entry(md_pkg::MD_REM,  2'b00, 32'hFFFF_FFF9, 32'h0000_0002, 32'h0000_0001);
    add_entry(md_pkg::MD_DIV,  2'b11, 32'h0000_0007, 32'hFFFF_FFFE, 32'hFFFF_FFFD);
    add_entry(md_pkg::MD_REM,  2'b11, 32'h0000_0007, 32'hFFFF_FFFE, 32'h0000_0001);
    add_entry(md_pkg::MD_DIV,  2'b10, 32'h0000_0064, 32'hFFFF_FFF6, 32'hFFFF_FFF6);
    add_entry(md_pkg::MD_DIV,  2'b01, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_entry(md_pkg::MD_REM,  2'b01, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_entry(md_pkg::MD_DIV,  2'b11, 32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF);
    add_entry(md_pkg::MD_REM,  2'b00, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    add_entry(md_pkg::MD_REM,  2'b11, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
    // Long divide followed by a short multiply that overtakes it
    add_entry(md_pkg::MD_DIV,  2'b00, 32'h0000_0064, 32'h0000_0007, 32'h0000_000E);
    add_entry(md_pkg::MD_MUL,  2'b00, 32'h0000_FFFF, 32'h0000_FFFF, 32'hFFFE_0001);
  endtask

  task automatic add_random_entries();
    logic [31:0]      ra, rb, rc;
    md_pkg::md_op_e   op;
    md_pkg::md_sign_t sm;
    md_pkg::word_t    b;
    for (int i = 0; i < NUM_RAND; i++) begin
      ra = next_rand();
      rb = next_rand();
      rc = next_rand();
      op = md_pkg::md_op_e'(rc[31:30]);
      sm = rc[29:28];
      // Shifted divisors spread the quotient sizes and a few are zero
      b  = (rc[27:25] == 3'd0) ? '0 : (rb >> rc[24:20]);
      add_entry(op, sm, ra, b, model_result(op, sm, ra, b));
    end
  endtask

  task automatic check_word(input string name, input md_pkg::word_t exp,
      input md_pkg::word_t act);
    if (act !== exp) begin
      err_value++;
      $display("** Error: %s expected 0x%08h got 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_tag(input logic [TAG_W-1:0] tag, output bit ok);
    ok = busy[tag];
    if (!ok) begin
      err_tag++;
      $display("** Error: res_tag_o 0x%h has no outstanding request", tag);
    end
  endtask

  // Puts the payload of an entry on the request lines, valid follows later
  task automatic drive_entry(input int i);
    req_op_i    = ent_op[i];
    req_sign_i  = ent_sign[i];
    req_a_i     = ent_a[i];
    req_b_i     = ent_b[i];
    req_tag_i   = i[TAG_W-1:0];
  endtask

  task automatic print_counts();
    $display("Errors: %0d value, %0d tag, %0d other", err_value, err_tag, err_other);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d of %0d results did not arrive",
             cycles, n_entries - done_cnt, n_entries);
    print_counts();
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    bit               got;
    bit               ok;
    bit               req_fired;
    bit               staged;
    logic [TAG_W-1:0] tag;
    logic [31:0]      r;
    int               issue_idx;
    int               max_done;
    int               ooo_cnt;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = md_pkg::MD_MUL;
    req_sign_i  = '0;
    req_a_i     = '0;
    req_b_i     = '0;
    req_tag_i   = '0;
    res_ready_i = 1'b0;
    req_fired   = 1'b0;
    staged      = 1'b0;
    issue_idx   = 0;
    max_done    = -1;
    ooo_cnt     = 0;
    load_table();
    add_random_entries();
    n_entries   = ent_op.size();
    cycle_limit = 40 * n_entries + 200;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    while (done_cnt < n_entries) begin
      @(negedge clk_i);
      // Result outputs do not depend on res_ready_i, so the transfer is known here
      got = res_valid_o;
      r   = next_rand();
      res_ready_i = (r[31:30] != 2'b00);
      if (got && res_ready_i) begin
        check_tag(res_tag_o, ok);
        if (ok) begin
          tag = res_tag_o;
          check_word($sformatf("res_data_o entry %0d", idx_of_tag[tag]),
                     exp_of_tag[tag], res_data_o);
          busy[tag] = 1'b0;
          if (idx_of_tag[tag] < max_done) begin
            ooo_cnt++;
          end else begin
            max_done = idx_of_tag[tag];
          end
          done_cnt++;
        end
      end
      // The request taken at the last edge is gone
      if (req_fired) begin
        req_fired   = 1'b0;
        req_valid_i = 1'b0;
        staged      = 1'b0;
      end
      // Payload leads valid by a cycle so that req_ready_o has settled
      if (!req_valid_i && issue_idx < n_entries) begin
        if (!staged) begin
          drive_entry(issue_idx);
          staged = 1'b1;
        end else if (!busy[issue_idx[TAG_W-1:0]]) begin
          req_valid_i = 1'b1;
        end
      end
      // Valid and ready both high now, so the request is taken at the coming edge
      if (req_valid_i && req_ready_o) begin
        tag             = req_tag_i;
        busy[tag]       = 1'b1;
        exp_of_tag[tag] = ent_exp[issue_idx];
        idx_of_tag[tag] = issue_idx;
        issue_idx++;
        req_fired = 1'b1;
      end
    end

    // No result may arrive once every entry is back
    req_valid_i = 1'b0;
    res_ready_i = 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      if (res_valid_o) begin
        err_other++;
        $display("Unexpected extra result with tag 0x%h", res_tag_o);
      end
    end
    if (ooo_cnt == 0) begin
      err_other++;
      $display("No result completed out of order");
    end
    print_counts();
    if (err_value + err_tag + err_other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sim.f
md_pkg.sv
md_mult.sv
md_div.sv
md_port_arb.sv
md_top.sv
md_sva.sv
tb_md.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_md -f sim.f
out=$(./obj_dir/Vtb_md 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
  exit 0
fi
exit 1
